//--- logic/awp_pkg.sv
`default_nettype none

package awp_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Quad count fixes the payload layout
    localparam int NUM_QUADS = 4;
    localparam int PIXEL_W   = 8;
    localparam int WEIGHT_W  = 8;
    // Four 255 x 255 products fit in 18 bits
    localparam int SUM_W     = 18;
    localparam int TAG_W     = 8;
    localparam int SEQ_W     = 8;

    ////////////////////
    // Opcodes
    ////////////////////

    typedef enum logic [1:0] {
        OP_NOP         = 2'd0,
        OP_CFG_WEIGHTS = 2'd1,
        OP_PIXELS      = 2'd2,
        OP_RSVD        = 2'd3
    } awp_op_e;

    ////////////////////
    // Words
    ////////////////////

    // Ingress word, byte i of payload goes to quad i
    typedef struct packed {
        awp_op_e                                op;
        logic [TAG_W-1:0]                       tag;
        logic [NUM_QUADS-1:0][PIXEL_W-1:0]      payload;
    } trans_in_t;

    // Token passed down the quad chain
    typedef struct packed {
        logic [TAG_W-1:0]                       tag;
        logic [NUM_QUADS-1:0][PIXEL_W-1:0]      pix;
        logic [SUM_W-1:0]                       sum;
    } cascade_t;

    // Egress word
    typedef struct packed {
        logic [TAG_W-1:0]                       tag;
        logic [SEQ_W-1:0]                       seq;
        logic [SUM_W-1:0]                       sum;
    } trans_eg_t;

endpackage

`default_nettype wire

//--- logic/sync_fifo.sv
`default_nettype none

module sync_fifo #(
    parameter int  DEPTH = 4,
    parameter type T     = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic push_valid,
    output logic push_ready,
    input  T     push_data,
    output logic pop_valid,
    input  logic pop_ready,
    output T     pop_data
);

    // Pointer width, kept at one bit for a single-entry FIFO
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T               mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic [CW-1:0]  count_next;
    logic           push_fire;
    logic           pop_fire;

    assign push_fire = push_valid && push_ready;
    assign pop_fire  = pop_valid && pop_ready;

    // Head word shows without a read request
    assign pop_valid = (count != '0);
    assign pop_data  = mem[rd_ptr];

    always_comb begin
        count_next = count + CW'(push_fire) - CW'(pop_fire);
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers, count and registered ready
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            push_ready <= 1'b0;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // Refuse pushes once full
            push_ready <= (count_next != CW'(DEPTH));
        end
    end

endmodule

`default_nettype wire

//--- logic/trans_decoder.sv
`default_nettype none

module trans_decoder (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    in_valid,
    output logic                                                    in_ready,
    input  awp_pkg::trans_in_t                                      in_word,
    input  logic                                                    chain_idle,
    output logic                                                    weight_load,
    output logic [awp_pkg::NUM_QUADS-1:0][awp_pkg::WEIGHT_W-1:0]    weight_vec,
    output logic                                                    tok_valid,
    input  logic                                                    tok_ready,
    output awp_pkg::cascade_t                                       tok
);

    typedef enum logic [0:0] {
        DEC_IDLE       = 1'b0,
        DEC_WAIT_DRAIN = 1'b1
    } dec_state_e;

    dec_state_e state;
    dec_state_e state_next;

    ////////////////////
    // Token and weights
    ////////////////////

    // Token built straight from the head word, sum starts at zero
    always_comb begin
        tok.tag    = in_word.tag;
        tok.pix    = in_word.payload;
        tok.sum    = '0;
        weight_vec = in_word.payload;
    end

    ////////////////////
    // Opcode FSM
    ////////////////////

    always_comb begin
        state_next  = state;
        in_ready    = 1'b0;
        tok_valid   = 1'b0;
        weight_load = 1'b0;
        case (state)
            DEC_IDLE: begin
                if (in_valid) begin
                    case (in_word.op)
                        awp_pkg::OP_PIXELS: begin
                            // Pop when quad 0 takes the token
                            tok_valid = 1'b1;
                            in_ready  = tok_ready;
                        end
                        awp_pkg::OP_CFG_WEIGHTS: begin
                            // Hold config until nothing is in flight
                            state_next = DEC_WAIT_DRAIN;
                        end
                        default: begin
                            // NOP and reserved are dropped
                            in_ready = 1'b1;
                        end
                    endcase
                end
            end
            DEC_WAIT_DRAIN: begin
                // No launch here, so chain_idle alone is enough
                if (chain_idle) begin
                    weight_load = 1'b1;
                    in_ready    = 1'b1;
                    state_next  = DEC_IDLE;
                end
            end
            default: begin
                state_next = DEC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DEC_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/conv_quad.sv
`default_nettype none

module conv_quad #(
    parameter int QUAD_INDEX = 0
) (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    weight_load,
    input  logic [awp_pkg::NUM_QUADS-1:0][awp_pkg::WEIGHT_W-1:0]    weight_vec,
    input  logic                                                    in_valid,
    output logic                                                    in_ready,
    input  awp_pkg::cascade_t                                       in_tok,
    output logic                                                    out_valid,
    input  logic                                                    out_ready,
    output awp_pkg::cascade_t                                       out_tok
);

    logic [awp_pkg::WEIGHT_W-1:0]                   weight_q;
    logic [awp_pkg::PIXEL_W+awp_pkg::WEIGHT_W-1:0]  product;
    logic                                           in_fire;

    // Stage can take a token when empty or being drained
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    // This quad's pixel byte times its weight
    assign product = in_tok.pix[QUAD_INDEX] * weight_q;

    // Own weight byte
    always_ff @(posedge clk) begin
        if (rst) begin
            weight_q <= '0;
        end else if (weight_load) begin
            weight_q <= weight_vec[QUAD_INDEX];
        end
    end

    // Registered MAC stage
    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_tok.tag <= in_tok.tag;
            out_tok.pix <= in_tok.pix;
            out_tok.sum <= in_tok.sum + awp_pkg::SUM_W'(product);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/quad_chain.sv
`default_nettype none

module quad_chain #(
    parameter int CASCADE_DEPTH = 2
) (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    weight_load,
    input  logic [awp_pkg::NUM_QUADS-1:0][awp_pkg::WEIGHT_W-1:0]    weight_vec,
    input  logic                                                    in_valid,
    output logic                                                    in_ready,
    input  awp_pkg::cascade_t                                       in_tok,
    output logic                                                    done_valid,
    input  logic                                                    done_ready,
    output awp_pkg::cascade_t                                       done,
    output logic                                                    chain_idle
);

    localparam int NQ = awp_pkg::NUM_QUADS;

    // Per-quad handshake
    logic [NQ-1:0]      q_in_valid;
    logic [NQ-1:0]      q_in_ready;
    awp_pkg::cascade_t  q_in_tok [NQ];
    logic [NQ-1:0]      q_out_valid;
    logic [NQ-1:0]      q_out_ready;
    awp_pkg::cascade_t  q_out_tok [NQ];

    // Head of the chain
    assign q_in_valid[0] = in_valid;
    assign q_in_tok[0]   = in_tok;
    assign in_ready      = q_in_ready[0];

    // Tail leaves as done
    assign done_valid          = q_out_valid[NQ-1];
    assign done                = q_out_tok[NQ-1];
    assign q_out_ready[NQ-1]   = done_ready;

    for (genvar gi = 0; gi < NQ; gi++) begin : g_quad
        conv_quad #(
            .QUAD_INDEX (gi)
        ) quad_i (
            .clk         (clk),
            .rst         (rst),
            .weight_load (weight_load),
            .weight_vec  (weight_vec),
            .in_valid    (q_in_valid[gi]),
            .in_ready    (q_in_ready[gi]),
            .in_tok      (q_in_tok[gi]),
            .out_valid   (q_out_valid[gi]),
            .out_ready   (q_out_ready[gi]),
            .out_tok     (q_out_tok[gi])
        );

        // Cascade FIFO into the next quad
        if (gi < NQ - 1) begin : g_cascade
            sync_fifo #(
                .DEPTH (CASCADE_DEPTH),
                .T     (awp_pkg::cascade_t)
            ) cascade_fifo_i (
                .clk        (clk),
                .rst        (rst),
                .push_valid (q_out_valid[gi]),
                .push_ready (q_out_ready[gi]),
                .push_data  (q_out_tok[gi]),
                .pop_valid  (q_in_valid[gi+1]),
                .pop_ready  (q_in_ready[gi+1]),
                .pop_data   (q_in_tok[gi+1])
            );
        end
    end

    // Idle when no stage, no cascade FIFO and no launch holds a token
    assign chain_idle = !(|q_out_valid) && !(|q_in_valid);

endmodule

`default_nettype wire

//--- logic/result_packer.sv
`default_nettype none

module result_packer (
    input  logic                clk,
    input  logic                rst,
    input  logic                done_valid,
    output logic                done_ready,
    input  awp_pkg::cascade_t   done,
    output logic                eg_valid,
    input  logic                eg_ready,
    output awp_pkg::trans_eg_t  eg_word
);

    logic [awp_pkg::SEQ_W-1:0] seq_q;

    // Straight pass-through, egress FIFO ready is the stall
    assign eg_valid   = done_valid;
    assign done_ready = eg_ready;

    always_comb begin
        eg_word.tag = done.tag;
        eg_word.seq = seq_q;
        eg_word.sum = done.sum;
    end

    // One step per pushed result
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_q <= '0;
        end else if (eg_valid && eg_ready) begin
            seq_q <= seq_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/awp_top.sv
`default_nettype none

module awp_top #(
    parameter int IN_DEPTH      = 4,
    parameter int CASCADE_DEPTH = 2,
    parameter int EG_DEPTH      = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  awp_pkg::trans_in_t  in_data,
    output logic                out_valid,
    input  logic                out_ready,
    output awp_pkg::trans_eg_t  out_data
);

    ////////////////////
    // Wires
    ////////////////////

    // Ingress head to decoder
    logic                   head_valid;
    logic                   head_ready;
    awp_pkg::trans_in_t     head_word;
    // Decoder to chain
    logic                   weight_load;
    logic [awp_pkg::NUM_QUADS-1:0][awp_pkg::WEIGHT_W-1:0] weight_vec;
    logic                   tok_valid;
    logic                   tok_ready;
    awp_pkg::cascade_t      tok;
    logic                   chain_idle;
    // Chain to packer to egress
    logic                   done_valid;
    logic                   done_ready;
    awp_pkg::cascade_t      done;
    logic                   eg_valid;
    logic                   eg_ready;
    awp_pkg::trans_eg_t     eg_word;

    ////////////////////
    // Datapath
    ////////////////////

    sync_fifo #(
        .DEPTH (IN_DEPTH),
        .T     (awp_pkg::trans_in_t)
    ) in_fifo_i (
        .clk        (clk),
        .rst        (rst),
        .push_valid (in_valid),
        .push_ready (in_ready),
        .push_data  (in_data),
        .pop_valid  (head_valid),
        .pop_ready  (head_ready),
        .pop_data   (head_word)
    );

    trans_decoder decoder_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (head_valid),
        .in_ready    (head_ready),
        .in_word     (head_word),
        .chain_idle  (chain_idle),
        .weight_load (weight_load),
        .weight_vec  (weight_vec),
        .tok_valid   (tok_valid),
        .tok_ready   (tok_ready),
        .tok         (tok)
    );

    quad_chain #(
        .CASCADE_DEPTH (CASCADE_DEPTH)
    ) chain_i (
        .clk         (clk),
        .rst         (rst),
        .weight_load (weight_load),
        .weight_vec  (weight_vec),
        .in_valid    (tok_valid),
        .in_ready    (tok_ready),
        .in_tok      (tok),
        .done_valid  (done_valid),
        .done_ready  (done_ready),
        .done        (done),
        .chain_idle  (chain_idle)
    );

    result_packer packer_i (
        .clk        (clk),
        .rst        (rst),
        .done_valid (done_valid),
        .done_ready (done_ready),
        .done       (done),
        .eg_valid   (eg_valid),
        .eg_ready   (eg_ready),
        .eg_word    (eg_word)
    );

    sync_fifo #(
        .DEPTH (EG_DEPTH),
        .T     (awp_pkg::trans_eg_t)
    ) eg_fifo_i (
        .clk        (clk),
        .rst        (rst),
        .push_valid (eg_valid),
        .push_ready (eg_ready),
        .push_data  (eg_word),
        .pop_valid  (out_valid),
        .pop_ready  (out_ready),
        .pop_data   (out_data)
    );

endmodule

`default_nettype wire

//--- bench/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held over two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/awp_tb.sv
`default_nettype none

module awp_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS  = 5;
    localparam int WAIT_LIMIT = 400;

    // Table row with behavior number and ingress word
    typedef struct packed {
        logic [3:0]         test;
        awp_pkg::trans_in_t word;
    } stim_t;

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    awp_pkg::trans_in_t in_data;
    logic               out_valid;
    logic               out_ready;
    awp_pkg::trans_eg_t out_data;

    stim_t              stim_q [$];
    awp_pkg::trans_eg_t exp_q [$];
    // Running result count at the end of each test
    int                 test_goal [NUM_TESTS+1];
    string              test_name [NUM_TESTS+1];
    int                 errors;
    int                 rx_count;
    int                 tests_failed;
    bit                 random_ready;
    bit                 aborted;

    clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    awp_top #(
        .IN_DEPTH      (4),
        .CASCADE_DEPTH (2),
        .EG_DEPTH      (4)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, want);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        aborted = 1'b1;
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
    endtask

    // Sum over quads of pixel times weight
    function automatic int unsigned dot_sum(
        input logic [awp_pkg::NUM_QUADS-1:0][awp_pkg::PIXEL_W-1:0]  pix,
        input logic [awp_pkg::NUM_QUADS-1:0][awp_pkg::WEIGHT_W-1:0] w
    );
        int unsigned acc;
        acc = 0;
        for (int q = 0; q < awp_pkg::NUM_QUADS; q++) begin
            acc += int'(pix[q]) * int'(w[q]);
        end
        return acc;
    endfunction

    task automatic add_row(input int test, input awp_pkg::awp_op_e op,
                           input logic [7:0] tag, input logic [31:0] payload);
        stim_t row;
        row.test         = 4'(test);
        row.word.op      = op;
        row.word.tag     = tag;
        row.word.payload = payload;
        stim_q.push_back(row);
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic load_table();
        test_name[1] = "after reset";
        test_name[2] = "dot product";
        test_name[3] = "reconfiguration";
        test_name[4] = "dropped opcodes";
        test_name[5] = "back-pressure";
        // Pixels on zero weights before a first config
        add_row(1, awp_pkg::OP_PIXELS,      8'h01, 32'h1122_3344);
        add_row(1, awp_pkg::OP_CFG_WEIGHTS, 8'h00, 32'h0403_0201);
        add_row(1, awp_pkg::OP_PIXELS,      8'h02, 32'h0101_0101);
        // Full-scale sum and mixed bytes
        add_row(2, awp_pkg::OP_CFG_WEIGHTS, 8'h00, 32'hffff_ffff);
        add_row(2, awp_pkg::OP_PIXELS,      8'h03, 32'hffff_ffff);
        add_row(2, awp_pkg::OP_PIXELS,      8'h04, 32'h0000_00ff);
        add_row(2, awp_pkg::OP_CFG_WEIGHTS, 8'h00, 32'h0a00_ff02);
        add_row(2, awp_pkg::OP_PIXELS,      8'h05, 32'h0309_1080);
        // Config lands behind tokens in flight
        add_row(3, awp_pkg::OP_CFG_WEIGHTS, 8'h00, 32'h0102_0304);
        add_row(3, awp_pkg::OP_PIXELS,      8'h10, 32'h0505_0505);
        add_row(3, awp_pkg::OP_PIXELS,      8'h11, 32'h1020_3040);
        add_row(3, awp_pkg::OP_CFG_WEIGHTS, 8'h00, 32'h0908_0706);
        add_row(3, awp_pkg::OP_PIXELS,      8'h12, 32'h0505_0505);
        add_row(3, awp_pkg::OP_PIXELS,      8'h13, 32'h1020_3040);
        add_row(3, awp_pkg::OP_CFG_WEIGHTS, 8'h00, 32'h0000_0001);
        add_row(3, awp_pkg::OP_PIXELS,      8'h14, 32'hffff_ffff);
        // Drops between pixels
        add_row(4, awp_pkg::OP_NOP,         8'h20, 32'haaaa_aaaa);
        add_row(4, awp_pkg::OP_RSVD,        8'h21, 32'h5555_5555);
        add_row(4, awp_pkg::OP_PIXELS,      8'h22, 32'h0102_0304);
        add_row(4, awp_pkg::OP_NOP,         8'h23, 32'h0000_0000);
        add_row(4, awp_pkg::OP_RSVD,        8'h24, 32'hffff_ffff);
        add_row(4, awp_pkg::OP_PIXELS,      8'h25, 32'h80ff_0010);
        // Random out_ready from here on
        add_row(5, awp_pkg::OP_CFG_WEIGHTS, 8'h00, 32'h3344_5566);
        add_row(5, awp_pkg::OP_PIXELS,      8'h30, 32'h0102_0304);
        add_row(5, awp_pkg::OP_PIXELS,      8'h31, 32'hfe01_7c44);
        add_row(5, awp_pkg::OP_PIXELS,      8'h32, 32'h0000_0000);
        add_row(5, awp_pkg::OP_PIXELS,      8'h33, 32'h9a9a_1234);
        add_row(5, awp_pkg::OP_CFG_WEIGHTS, 8'h00, 32'h8001_7f02);
        add_row(5, awp_pkg::OP_PIXELS,      8'h34, 32'h6b2c_ee05);
        add_row(5, awp_pkg::OP_NOP,         8'h35, 32'h1111_1111);
        add_row(5, awp_pkg::OP_PIXELS,      8'h36, 32'hffff_0001);
        add_row(5, awp_pkg::OP_PIXELS,      8'h37, 32'h4040_4040);
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Weight register and sequence counter walked in table order
    task automatic build_expected();
        logic [awp_pkg::NUM_QUADS-1:0][awp_pkg::WEIGHT_W-1:0] w;
        logic [awp_pkg::SEQ_W-1:0] seq;
        awp_pkg::trans_eg_t        e;
        w         = '0;
        seq       = '0;
        test_goal = '{default: 0};
        foreach (stim_q[i]) begin
            case (stim_q[i].word.op)
                awp_pkg::OP_CFG_WEIGHTS: begin
                    w = stim_q[i].word.payload;
                end
                awp_pkg::OP_PIXELS: begin
                    e.tag = stim_q[i].word.tag;
                    e.seq = seq;
                    e.sum = awp_pkg::SUM_W'(dot_sum(stim_q[i].word.payload, w));
                    exp_q.push_back(e);
                    seq++;
                end
                default: begin
                end
            endcase
            test_goal[stim_q[i].test] = exp_q.size();
        end
    endtask

    ////////////////////
    // Driving and waiting
    ////////////////////

    // Called on a falling edge and returns on one
    task automatic send_word(input awp_pkg::trans_in_t w);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_data  = w;
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (in_ready) begin
            @(negedge clk);
        end else begin
            note_timeout("in_ready");
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        @(negedge clk);
        while (rst && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rst) begin
            note_timeout("reset release");
        end
    endtask

    task automatic wait_results(input int goal);
        int waited;
        waited = 0;
        while (rx_count < goal && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rx_count < goal) begin
            note_timeout("egress results");
        end
    endtask

    ////////////////////
    // Collector
    ////////////////////

    // Ready set on the falling edge and data taken at the next rising edge
    initial begin : collector
        awp_pkg::trans_eg_t want;
        void'($urandom(32'h0a3c_1e91));
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (rst) begin
                out_ready = 1'b0;
            end else if (random_ready) begin
                out_ready = (($urandom % 3) == 0);
            end else begin
                out_ready = 1'b1;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected output at %0t with tag 0x%0h", $time, out_data.tag);
                end else begin
                    want = exp_q.pop_front();
                    check_value("out_data.tag", 32'(out_data.tag), 32'(want.tag));
                    check_value("out_data.seq", 32'(out_data.seq), 32'(want.seq));
                    check_value("out_data.sum", 32'(out_data.sum), 32'(want.sum));
                end
                rx_count++;
            end
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin : main
        int idx;
        int base_err;
        in_valid     = 1'b0;
        in_data      = '0;
        errors       = 0;
        rx_count     = 0;
        tests_failed = 0;
        random_ready = 1'b0;
        aborted      = 1'b0;
        idx          = 0;
        load_table();
        build_expected();

        wait_reset();
        // Egress empty straight out of reset
        check_value("out_valid", 32'(out_valid), 32'd0);

        for (int t = 1; t <= NUM_TESTS && !aborted; t++) begin
            base_err     = errors;
            random_ready = (t == 5);
            while (idx < stim_q.size() && stim_q[idx].test == 4'(t) && !aborted) begin
                send_word(stim_q[idx].word);
                idx++;
            end
            if (!aborted) begin
                wait_results(test_goal[t]);
            end
            if (errors == base_err) begin
                $display("test %0d (%s): ok", t, test_name[t]);
            end else begin
                tests_failed++;
                $display("test %0d (%s): %0d errors", t, test_name[t], errors - base_err);
            end
        end

        // Idle window where the collector still catches a late word
        random_ready = 1'b0;
        repeat (30) @(negedge clk);

        $display("tests %0d, failed %0d, errors %0d, results %0d", NUM_TESTS, tests_failed,
                 errors, rx_count);
        if (errors == 0 && !aborted) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
logic/awp_pkg.sv
logic/sync_fifo.sv
logic/trans_decoder.sv
logic/conv_quad.sv
logic/quad_chain.sv
logic/result_packer.sv
logic/awp_top.sv
bench/clk_gen.sv
bench/awp_tb.sv

//--- Makefile
TOP := awp_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

# Build, run, then decide on the log
sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
